// ==== arm_pkg.sv ====
package arm_pkg;

    //////////////////////////////////////////////////
    // word sizes
    //////////////////////////////////////////////////

    // data path width
    localparam int WORD = 32;
    // thumb instruction width
    localparam int HALF_WORD = 16;
    // low registers r0 to r7 only
    localparam int ADDR_WIDTH = 3;

    //////////////////////////////////////////////////
    // decode control
    //////////////////////////////////////////////////

    // pass forwards operand 2 unchanged, used by mov
    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_EOR,
        ALU_ORR
    } alu_control_signal;

    typedef enum logic {
        SRC_REG,
        SRC_IMM
    } alu_input_source;

    typedef enum logic {
        REG_WRITE_DIS,
        REG_WRITE_EN
    } reg_file_write_sig;

endpackage

// ==== program_counter.sv ====
`timescale 1ns/1ps

module program_counter #(
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     program_mem_write_en_i,
    input  logic                     stall_pipeline_i,
    output logic                     is_valid_o,
    output logic [arm_pkg::WORD-1:0] program_counter_o
);
    import arm_pkg::*;

    // byte address of the last halfword before wrap
    localparam int LAST_ADDR = 2 * (PROGRAM_DEPTH - 1);

    always_ff @(posedge clk_i) begin
        if (reset_i || program_mem_write_en_i) begin
            program_counter_o <= '0;
            is_valid_o        <= 1'b0;
        end else if (!is_valid_o) begin
            // first cycle after reset or load, address zero not yet fetched
            is_valid_o <= 1'b1;
        end else if (!stall_pipeline_i) begin
            if (program_counter_o == WORD'(LAST_ADDR))
                program_counter_o <= '0;
            else
                program_counter_o <= program_counter_o + WORD'(2);
        end
    end

    // halfword fetch never lands on an odd byte
    a_pc_even: assert property (@(posedge clk_i) disable iff (reset_i)
        program_counter_o[0] == 1'b0);

endmodule

// ==== instruction_mem.sv ====
`timescale 1ns/1ps

module instruction_mem #(
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          program_mem_write_en_i,
    input  logic                          is_valid_i,
    input  logic                          stall_pipeline_i,
    input  logic [arm_pkg::HALF_WORD-1:0] instruction_i,
    input  logic [arm_pkg::WORD-1:0]      instruction_addr_i,
    output logic                          is_valid_o,
    output logic [arm_pkg::HALF_WORD-1:0] instruction_o
);
    import arm_pkg::*;

    localparam int INDEX_WIDTH = $clog2(PROGRAM_DEPTH);

    logic [HALF_WORD-1:0]   mem_array [PROGRAM_DEPTH];
    logic [INDEX_WIDTH-1:0] mem_index;

    // byte address to halfword slot
    assign mem_index = instruction_addr_i[INDEX_WIDTH:1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // unloaded memory reads as halfword zero, a no-op
            for (int i = 0; i < PROGRAM_DEPTH; i++) begin
                mem_array[i] <= '0;
            end
            is_valid_o <= 1'b0;
        end else if (program_mem_write_en_i) begin
            mem_array[mem_index] <= instruction_i;
            is_valid_o           <= 1'b0;
        end else if (!stall_pipeline_i) begin
            instruction_o <= mem_array[mem_index];
            is_valid_o    <= is_valid_i;
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           write_en_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] write_addr_i,
    input  logic [arm_pkg::WORD-1:0]       write_data_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] read_addr_1_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] read_addr_2_i,
    output logic [arm_pkg::WORD-1:0]       read_data_1_o,
    output logic [arm_pkg::WORD-1:0]       read_data_2_o
);
    import arm_pkg::*;

    logic [WORD-1:0] regs [2**ADDR_WIDTH];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en_i) begin
            regs[write_addr_i] <= write_data_i;
        end
    end

    // write-through, so decode sees the write-back of this cycle
    assign read_data_1_o = (write_en_i && write_addr_i == read_addr_1_i) ?
                           write_data_i : regs[read_addr_1_i];
    assign read_data_2_o = (write_en_i && write_addr_i == read_addr_2_i) ?
                           write_data_i : regs[read_addr_2_i];

endmodule

// ==== decode_block.sv ====
`timescale 1ns/1ps

module decode_block (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           is_valid_i,
    input  logic                           reg_file_write_en_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] reg_write_addr_i,
    input  logic [arm_pkg::WORD-1:0]       reg_data_i,
    input  logic [arm_pkg::HALF_WORD-1:0]  instruction_i,
    output arm_pkg::alu_control_signal     alu_control_signal_o,
    output arm_pkg::alu_input_source       alu_input_2_select_o,
    output arm_pkg::reg_file_write_sig     reg_file_write_en_o,
    output logic [arm_pkg::ADDR_WIDTH-1:0] reg_dest_addr_o,
    output logic [arm_pkg::WORD-1:0]       immediate_o,
    output logic [arm_pkg::WORD-1:0]       reg_1_data_o,
    output logic [arm_pkg::WORD-1:0]       reg_2_data_o,
    output logic                           pipeline_ctrl_sig_o,
    output logic                           is_valid_o
);
    import arm_pkg::*;

    alu_control_signal     alu_op;
    alu_input_source       src_2_sel;
    reg_file_write_sig     write_en;
    logic [ADDR_WIDTH-1:0] read_addr_1;
    logic [ADDR_WIDTH-1:0] read_addr_2;
    logic [ADDR_WIDTH-1:0] dest_addr;
    logic [WORD-1:0]       imm_ext;
    logic [WORD-1:0]       read_data_1;
    logic [WORD-1:0]       read_data_2;
    logic                  uses_reg_1;
    logic                  uses_reg_2;
    logic                  ex_writes;

    //////////////////////////////////////////////////
    // thumb field decode
    //////////////////////////////////////////////////
    always_comb begin
        alu_op      = ALU_PASS;
        src_2_sel   = SRC_REG;
        write_en    = REG_WRITE_DIS;
        read_addr_1 = instruction_i[2:0];
        read_addr_2 = instruction_i[5:3];
        dest_addr   = instruction_i[2:0];
        imm_ext     = WORD'(instruction_i[7:0]);
        uses_reg_1  = 1'b0;
        uses_reg_2  = 1'b0;
        if (instruction_i[15:13] == 3'b001) begin
            // format 3, rd op imm8 (cmp has no flags here, stays a no-op)
            dest_addr   = instruction_i[10:8];
            read_addr_1 = instruction_i[10:8];
            src_2_sel   = SRC_IMM;
            case (instruction_i[12:11])
                2'b00: write_en = REG_WRITE_EN;
                2'b10: begin
                    alu_op     = ALU_ADD;
                    write_en   = REG_WRITE_EN;
                    uses_reg_1 = 1'b1;
                end
                2'b11: begin
                    alu_op     = ALU_SUB;
                    write_en   = REG_WRITE_EN;
                    uses_reg_1 = 1'b1;
                end
                default: write_en = REG_WRITE_DIS;
            endcase
        end else if (instruction_i[15:10] == 6'b000110) begin
            // format 2 register form, rd = rs +/- rn
            read_addr_1 = instruction_i[5:3];
            read_addr_2 = instruction_i[8:6];
            alu_op      = instruction_i[9] ? ALU_SUB : ALU_ADD;
            write_en    = REG_WRITE_EN;
            uses_reg_1  = 1'b1;
            uses_reg_2  = 1'b1;
        end else if (instruction_i[15:10] == 6'b010000) begin
            // format 4, rd = rd op rs
            uses_reg_1 = 1'b1;
            uses_reg_2 = 1'b1;
            write_en   = REG_WRITE_EN;
            case (instruction_i[9:6])
                4'b0000: alu_op = ALU_AND;
                4'b0001: alu_op = ALU_EOR;
                4'b1100: alu_op = ALU_ORR;
                default: write_en = REG_WRITE_DIS;
            endcase
        end
    end

    reg_file i_reg_file (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .write_en_i   (reg_file_write_en_i),
        .write_addr_i (reg_write_addr_i),
        .write_data_i (reg_data_i),
        .read_addr_1_i(read_addr_1),
        .read_addr_2_i(read_addr_2),
        .read_data_1_o(read_data_1),
        .read_data_2_o(read_data_2)
    );

    //////////////////////////////////////////////////
    // hazard against the instruction in execute
    //////////////////////////////////////////////////
    assign ex_writes = is_valid_o && (reg_file_write_en_o == REG_WRITE_EN);
    assign pipeline_ctrl_sig_o = is_valid_i && ex_writes &&
        ((uses_reg_1 && reg_dest_addr_o == read_addr_1) ||
         (uses_reg_2 && reg_dest_addr_o == read_addr_2));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            is_valid_o          <= 1'b0;
            reg_file_write_en_o <= REG_WRITE_DIS;
        end else if (pipeline_ctrl_sig_o) begin
            // bubble to execute, instruction waits here
            is_valid_o <= 1'b0;
        end else begin
            is_valid_o          <= is_valid_i;
            reg_file_write_en_o <= write_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!pipeline_ctrl_sig_o) begin
            alu_control_signal_o <= alu_op;
            alu_input_2_select_o <= src_2_sel;
            reg_dest_addr_o      <= dest_addr;
            immediate_o          <= imm_ext;
            reg_1_data_o         <= read_data_1;
            reg_2_data_o         <= read_data_2;
        end
    end

    a_stall_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(pipeline_ctrl_sig_o) |-> is_valid_i);

endmodule

// ==== execute_block.sv ====
`timescale 1ns/1ps

module execute_block (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           is_valid_i,
    input  arm_pkg::alu_control_signal     alu_control_signal_i,
    input  arm_pkg::alu_input_source       alu_input_2_select_i,
    input  arm_pkg::reg_file_write_sig     reg_file_write_en_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] reg_dest_addr_i,
    input  logic [arm_pkg::WORD-1:0]       immediate_i,
    input  logic [arm_pkg::WORD-1:0]       reg_1_data_i,
    input  logic [arm_pkg::WORD-1:0]       reg_2_data_i,
    output logic                           wb_valid_o,
    output logic [arm_pkg::ADDR_WIDTH-1:0] wb_reg_o,
    output logic [arm_pkg::WORD-1:0]       wb_data_o
);
    import arm_pkg::*;

    logic [WORD-1:0] operand_2;
    logic [WORD-1:0] alu_result;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    assign operand_2 = (alu_input_2_select_i == SRC_IMM) ? immediate_i : reg_2_data_i;

    // add and sub simply wrap at 32 bits
    always_comb begin
        case (alu_control_signal_i)
            ALU_ADD: alu_result = reg_1_data_i + operand_2;
            ALU_SUB: alu_result = reg_1_data_i - operand_2;
            ALU_AND: alu_result = reg_1_data_i & operand_2;
            ALU_EOR: alu_result = reg_1_data_i ^ operand_2;
            ALU_ORR: alu_result = reg_1_data_i | operand_2;
            default: alu_result = operand_2;
        endcase
    end

    //////////////////////////////////////////////////
    // write-back register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i)
            wb_valid_o <= 1'b0;
        else
            wb_valid_o <= is_valid_i && (reg_file_write_en_i == REG_WRITE_EN);
    end

    always_ff @(posedge clk_i) begin
        if (is_valid_i) begin
            wb_reg_o  <= reg_dest_addr_i;
            wb_data_o <= alu_result;
        end
    end

    a_wb_quiet_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !wb_valid_o);

endmodule

// ==== arm_cpu.sv ====
`timescale 1ns/1ps

module arm_cpu #(
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           program_mem_write_en_i,
    input  logic [arm_pkg::HALF_WORD-1:0]  instruction_i,
    input  logic [arm_pkg::WORD-1:0]       instruction_addr_i,
    output logic                           wb_valid_o,
    output logic [arm_pkg::ADDR_WIDTH-1:0] wb_reg_o,
    output logic [arm_pkg::WORD-1:0]       wb_data_o
);
    import arm_pkg::*;

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////
    logic                 is_valid_pc_to_fetch;
    logic [WORD-1:0]      pc_to_fetch;
    logic [WORD-1:0]      fetch_addr;
    logic                 is_valid_fetch_to_decode;
    logic [HALF_WORD-1:0] instruction_fetch_to_decode;

    //////////////////////////////////////////////////
    // decode to execute
    //////////////////////////////////////////////////
    logic                  stall_from_decode;
    alu_control_signal     alu_control_signal_decode_to_exe;
    alu_input_source       alu_input_2_select_decode_to_exe;
    reg_file_write_sig     reg_file_write_en_decode_to_exe;
    logic [ADDR_WIDTH-1:0] reg_dest_addr_decode_to_exe;
    logic [WORD-1:0]       immediate_decode_to_exe;
    logic [WORD-1:0]       reg_1_data_decode_to_exe;
    logic [WORD-1:0]       reg_2_data_decode_to_exe;
    logic                  is_valid_decode_to_exe;

    // load address wins while a program is written
    assign fetch_addr = program_mem_write_en_i ? instruction_addr_i : pc_to_fetch;

    program_counter #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) i_program_counter (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .program_mem_write_en_i(program_mem_write_en_i),
        .stall_pipeline_i      (stall_from_decode),
        .is_valid_o            (is_valid_pc_to_fetch),
        .program_counter_o     (pc_to_fetch)
    );

    instruction_mem #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) i_instruction_mem (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .program_mem_write_en_i(program_mem_write_en_i),
        .is_valid_i            (is_valid_pc_to_fetch),
        .stall_pipeline_i      (stall_from_decode),
        .instruction_i         (instruction_i),
        .instruction_addr_i    (fetch_addr),
        .is_valid_o            (is_valid_fetch_to_decode),
        .instruction_o         (instruction_fetch_to_decode)
    );

    decode_block i_decode_block (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .is_valid_i          (is_valid_fetch_to_decode),
        .reg_file_write_en_i (wb_valid_o),
        .reg_write_addr_i    (wb_reg_o),
        .reg_data_i          (wb_data_o),
        .instruction_i       (instruction_fetch_to_decode),
        .alu_control_signal_o(alu_control_signal_decode_to_exe),
        .alu_input_2_select_o(alu_input_2_select_decode_to_exe),
        .reg_file_write_en_o (reg_file_write_en_decode_to_exe),
        .reg_dest_addr_o     (reg_dest_addr_decode_to_exe),
        .immediate_o         (immediate_decode_to_exe),
        .reg_1_data_o        (reg_1_data_decode_to_exe),
        .reg_2_data_o        (reg_2_data_decode_to_exe),
        .pipeline_ctrl_sig_o (stall_from_decode),
        .is_valid_o          (is_valid_decode_to_exe)
    );

    execute_block i_execute_block (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .is_valid_i          (is_valid_decode_to_exe),
        .alu_control_signal_i(alu_control_signal_decode_to_exe),
        .alu_input_2_select_i(alu_input_2_select_decode_to_exe),
        .reg_file_write_en_i (reg_file_write_en_decode_to_exe),
        .reg_dest_addr_i     (reg_dest_addr_decode_to_exe),
        .immediate_i         (immediate_decode_to_exe),
        .reg_1_data_i        (reg_1_data_decode_to_exe),
        .reg_2_data_i        (reg_2_data_decode_to_exe),
        .wb_valid_o          (wb_valid_o),
        .wb_reg_o            (wb_reg_o),
        .wb_data_o           (wb_data_o)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // released 1 ns after an edge, same as the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

// ==== arm_cpu_checker.sv ====
`timescale 1ns/1ps

module arm_cpu_checker (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           wb_valid_i,
    input  logic [arm_pkg::ADDR_WIDTH-1:0] wb_reg_i,
    input  logic [arm_pkg::WORD-1:0]       wb_data_i
);
    import arm_pkg::*;

    // expected write-backs in program order
    logic [ADDR_WIDTH-1:0] exp_reg_q [$];
    logic [WORD-1:0]       exp_data_q [$];

    int mismatch_count   = 0;
    int unexpected_count = 0;

    task automatic add_expected(input logic [ADDR_WIDTH-1:0] reg_idx,
                                input logic [WORD-1:0] value);
        exp_reg_q.push_back(reg_idx);
        exp_data_q.push_back(value);
    endtask

    function automatic int pending_count();
        return exp_reg_q.size();
    endfunction

    //////////////////////////////////////////////////
    // compare at mid-cycle, outputs are settled
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin
        logic [ADDR_WIDTH-1:0] exp_reg;
        logic [WORD-1:0]       exp_data;

        if (!reset_i && wb_valid_i) begin
            if (exp_reg_q.size() == 0) begin
                unexpected_count++;
                $display("write-back to r%0d with value %h at %0t ns, but none was expected",
                         wb_reg_i, wb_data_i, $time);
            end else begin
                exp_reg  = exp_reg_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (wb_reg_i !== exp_reg || wb_data_i !== exp_data) begin
                    mismatch_count++;
                    $display("[FAIL] %0t ns: write-back r%0d = %h, expected r%0d = %h",
                             $time, wb_reg_i, wb_data_i, exp_reg, exp_data);
                end
            end
        end
    end

endmodule

// ==== arm_cpu_tb.sv ====
`timescale 1ns/1ps

module arm_cpu_tb;
    import arm_pkg::*;

    localparam int PROGRAM_DEPTH = 64;
    localparam int RESET_TIMEOUT = 20;
    // stray write-backs from the rest of memory show up in here
    localparam int DRAIN_CYCLES  = 16;

    logic                  clk;
    logic                  reset;
    logic                  program_mem_write_en;
    logic [HALF_WORD-1:0]  instruction;
    logic [WORD-1:0]       instruction_addr;
    logic                  wb_valid;
    logic [ADDR_WIDTH-1:0] wb_reg;
    logic [WORD-1:0]       wb_data;

    int timeout_count = 0;
    int file_errors   = 0;

    tb_clock i_tb_clock (
        .clk_o  (clk),
        .reset_o(reset)
    );

    arm_cpu #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) i_arm_cpu (
        .clk_i                 (clk),
        .reset_i               (reset),
        .program_mem_write_en_i(program_mem_write_en),
        .instruction_i         (instruction),
        .instruction_addr_i    (instruction_addr),
        .wb_valid_o            (wb_valid),
        .wb_reg_o              (wb_reg),
        .wb_data_o             (wb_data)
    );

    arm_cpu_checker i_arm_cpu_checker (
        .clk_i     (clk),
        .reset_i   (reset),
        .wb_valid_i(wb_valid),
        .wb_reg_i  (wb_reg),
        .wb_data_i (wb_data)
    );

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////
    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = (reset === 1'b0);
    endtask

    task automatic load_halfword(input logic [WORD-1:0] addr,
                                 input logic [HALF_WORD-1:0] data);
        @(posedge clk);
        #1;
        program_mem_write_en = 1'b1;
        instruction_addr     = addr;
        instruction          = data;
    endtask

    // fetch starts at zero once the write enable drops
    task automatic run_program(input int budget, output bit done);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        program_mem_write_en = 1'b0;
        while (i_arm_cpu_checker.pending_count() > 0 && cycles < budget) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        done = (i_arm_cpu_checker.pending_count() == 0);
        if (done) begin
            repeat (DRAIN_CYCLES) @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // record loop over the cases file
    //////////////////////////////////////////////////
    initial begin
        int          fd;
        int          fields;
        int          total;
        logic [7:0]  kind;
        logic [31:0] field_a;
        logic [31:0] field_b;
        bit          ok;
        bit          done;
        bit          stop;

        program_mem_write_en = 1'b0;
        instruction          = '0;
        instruction_addr     = '0;
        stop                 = 1'b0;

        wait_reset_release(ok);
        if (!ok) begin
            $display("reset still high after %0d cycles", RESET_TIMEOUT);
            timeout_count++;
            stop = 1'b1;
        end

        fd = $fopen("arm_cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open arm_cpu_cases.txt for reading");
            file_errors++;
        end else begin
            while (!stop && $fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "L": begin
                        fields = $fscanf(fd, "%h %h", field_a, field_b);
                        if (fields == 2) begin
                            load_halfword(field_a, field_b[HALF_WORD-1:0]);
                        end
                    end
                    "E": begin
                        fields = $fscanf(fd, "%h %h", field_a, field_b);
                        if (fields == 2) begin
                            i_arm_cpu_checker.add_expected(field_a[ADDR_WIDTH-1:0], field_b);
                        end
                    end
                    "R": begin
                        fields = $fscanf(fd, "%d", field_a) + 1;
                        if (fields == 2) begin
                            run_program(field_a, done);
                            if (!done) begin
                                $display("timeout: %0d write-backs still missing after %0d cycles",
                                         i_arm_cpu_checker.pending_count(), field_a);
                                timeout_count++;
                                stop = 1'b1;
                            end
                        end
                    end
                    default: fields = 0;
                endcase
                if (fields != 2) begin
                    $display("malformed record of kind '%c' in arm_cpu_cases.txt", kind);
                    file_errors++;
                    stop = 1'b1;
                end
            end
            $fclose(fd);
        end

        total = i_arm_cpu_checker.mismatch_count + i_arm_cpu_checker.unexpected_count +
                timeout_count + file_errors;
        $display("error counts: mismatch %0d, unexpected %0d, timeout %0d, file %0d",
                 i_arm_cpu_checker.mismatch_count, i_arm_cpu_checker.unexpected_count,
                 timeout_count, file_errors);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
arm_pkg.sv
program_counter.sv
instruction_mem.sv
reg_file.sv
decode_block.sv
execute_block.sv
arm_cpu.sv
tb_clock.sv
arm_cpu_checker.sv
arm_cpu_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --assert
TOP       = arm_cpu_tb
FILE_LIST = verilog.f
BUILD_DIR = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== arm_cpu_cases.txt ====
L 0000 2801
L 0002 1c49
L 0004 4080
L 0006 43c0
L 0008 e000
L 000a 205a
E 0 0000005a
R 40
L 0000 2012
L 0002 21ff
L 0004 2780
L 0006 3101
L 0008 3813
L 000a 3002
L 000c 3f80
E 0 00000012
E 1 000000ff
E 7 00000080
E 1 00000100
E 0 ffffffff
E 0 00000001
E 7 00000000
R 40
L 0000 220f
L 0002 233c
L 0004 18d4
L 0006 1aa5
L 0008 1b56
L 000a 19b6
L 000c 401a
L 000e 4063
L 0010 431e
E 2 0000000f
E 3 0000003c
E 4 0000004b
E 5 0000003c
E 6 ffffffd3
E 6 ffffffa6
E 2 0000000c
E 3 00000077
E 6 fffffff7
R 60
